// ==== logic/dcheck_pkg.sv ====
// Shared widths, encodings and mismatch codes for the data-side lockstep checker.
// RV32 only. The codes assume naturally aligned accesses and no split transfers.

package dcheck_pkg;

  // --------------------------------------------------
  // widths and queue sizing
  // --------------------------------------------------
  localparam int XLEN            = 32;
  localparam int ACC_QUEUE_DEPTH = 2;
  localparam int ACC_PTR_W       = (ACC_QUEUE_DEPTH > 1) ? $clog2(ACC_QUEUE_DEPTH) : 1;
  localparam int ACC_CNT_W       = $clog2(ACC_QUEUE_DEPTH + 1);

  // --------------------------------------------------
  // instruction encodings
  // --------------------------------------------------
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 gives both width and sign for loads, stores only use B, H and W
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // one instruction word seen as a load (I-type) or as a store (S-type)
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_view;
  } lsu_insn_u;

  // --------------------------------------------------
  // mismatch kinds
  // --------------------------------------------------
  localparam int KIND_W = 3;

  localparam logic [KIND_W-1:0] MM_NONE     = 3'd0;
  localparam logic [KIND_W-1:0] MM_ADDR     = 3'd1;
  localparam logic [KIND_W-1:0] MM_BE       = 3'd2;
  localparam logic [KIND_W-1:0] MM_DATA     = 3'd3;
  localparam logic [KIND_W-1:0] MM_ERR      = 3'd4;
  localparam logic [KIND_W-1:0] MM_MISSING  = 3'd5;
  localparam logic [KIND_W-1:0] MM_OVERFLOW = 3'd6;

endpackage

// ==== logic/dmem_access_tracker.sv ====
// Assumes at most one outstanding bus request and exactly one response per grant.
// A response that finds the queue full and no pop is dropped and flagged.

`timescale 1ns/1ps

module dmem_access_tracker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         dmem_req_i,
  input  logic                         dmem_gnt_i,
  input  logic                         dmem_we_i,
  input  logic [dcheck_pkg::XLEN-1:0]  dmem_addr_i,
  input  logic [3:0]                   dmem_be_i,
  input  logic [dcheck_pkg::XLEN-1:0]  dmem_wdata_i,
  input  logic                         dmem_rvalid_i,
  input  logic [dcheck_pkg::XLEN-1:0]  dmem_rdata_i,
  input  logic                         dmem_err_i,
  input  logic                         acc_pop_i,
  output logic                         acc_valid_o,
  output logic                         acc_we_o,
  output logic [dcheck_pkg::XLEN-1:0]  acc_addr_o,
  output logic [3:0]                   acc_be_o,
  output logic [dcheck_pkg::XLEN-1:0]  acc_data_o,
  output logic                         acc_err_o,
  output logic                         overflow_o
);
  import dcheck_pkg::*;

  logic            out_we_q;
  logic [XLEN-1:0] out_addr_q;
  logic [3:0]      out_be_q;
  logic [XLEN-1:0] out_wdata_q;

  logic            q_we   [ACC_QUEUE_DEPTH];
  logic [XLEN-1:0] q_addr [ACC_QUEUE_DEPTH];
  logic [3:0]      q_be   [ACC_QUEUE_DEPTH];
  logic [XLEN-1:0] q_data [ACC_QUEUE_DEPTH];
  logic            q_err  [ACC_QUEUE_DEPTH];

  logic [ACC_PTR_W-1:0] wr_ptr_q;
  logic [ACC_PTR_W-1:0] rd_ptr_q;
  logic [ACC_CNT_W-1:0] count_q;

  logic full;
  logic push;
  logic pop;

  // --------------------------------------------------
  // outstanding request
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (dmem_req_i && dmem_gnt_i) begin
      out_we_q    <= dmem_we_i;
      out_addr_q  <= dmem_addr_i;
      out_be_q    <= dmem_be_i;
      out_wdata_q <= dmem_wdata_i;
    end
  end

  // --------------------------------------------------
  // completed access queue
  // --------------------------------------------------
  assign full       = (count_q == ACC_CNT_W'(ACC_QUEUE_DEPTH));
  assign pop        = acc_pop_i && (count_q != '0);
  // a pop in the same cycle frees the slot the response needs
  assign push       = dmem_rvalid_i && (!full || pop);
  assign overflow_o = dmem_rvalid_i && full && !pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_we[wr_ptr_q]   <= out_we_q;
      q_addr[wr_ptr_q] <= out_addr_q;
      q_be[wr_ptr_q]   <= out_be_q;
      q_data[wr_ptr_q] <= out_we_q ? out_wdata_q : dmem_rdata_i;
      q_err[wr_ptr_q]  <= dmem_err_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ACC_PTR_W'(ACC_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ACC_PTR_W'(ACC_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign acc_valid_o = (count_q != '0);
  assign acc_we_o    = q_we[rd_ptr_q];
  assign acc_addr_o  = q_addr[rd_ptr_q];
  assign acc_be_o    = q_be[rd_ptr_q];
  assign acc_data_o  = q_data[rd_ptr_q];
  assign acc_err_o   = q_err[rd_ptr_q];

endmodule

// ==== logic/retire_lsu_decoder.sv ====
// Purely combinational; outputs are meaningful only while rvfi_valid is high.
// Illegal load/store widths fall back to a full word access.

`timescale 1ns/1ps

module retire_lsu_decoder (
  input  logic [31:0]                  rvfi_insn_i,
  input  logic [dcheck_pkg::XLEN-1:0]  rvfi_rs1_rdata_i,
  input  logic [dcheck_pkg::XLEN-1:0]  rvfi_rs2_rdata_i,
  output logic                         is_mem_o,
  output logic                         is_store_o,
  output logic [2:0]                   funct3_o,
  output logic [dcheck_pkg::XLEN-1:0]  exp_addr_o,
  output logic [3:0]                   exp_be_o,
  output logic [dcheck_pkg::XLEN-1:0]  exp_wdata_o
);
  import dcheck_pkg::*;

  lsu_insn_u       insn;
  logic            is_load;
  logic            is_store;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] addr;
  logic [1:0]      offset;

  assign insn = rvfi_insn_i;

  // opcode and funct3 sit at the same bits in both views
  assign is_load  = (insn.i_view.opcode == OPC_LOAD);
  assign is_store = (insn.s_view.opcode == OPC_STORE);

  assign imm = is_store ?
               {{(XLEN-12){insn.s_view.imm_hi[6]}}, insn.s_view.imm_hi, insn.s_view.imm_lo} :
               {{(XLEN-12){insn.i_view.imm[11]}}, insn.i_view.imm};

  assign addr   = rvfi_rs1_rdata_i + imm;
  assign offset = addr[1:0];

  always_comb begin
    case (insn.i_view.funct3)
      F3_B, F3_BU: begin
        exp_be_o    = 4'b0001 << offset;
        exp_wdata_o = {4{rvfi_rs2_rdata_i[7:0]}};
      end
      F3_H, F3_HU: begin
        exp_be_o    = 4'b0011 << offset;
        exp_wdata_o = {2{rvfi_rs2_rdata_i[15:0]}};
      end
      default: begin
        exp_be_o    = 4'b1111;
        exp_wdata_o = rvfi_rs2_rdata_i;
      end
    endcase
  end

  assign is_mem_o   = is_load || is_store;
  assign is_store_o = is_store;
  assign funct3_o   = insn.i_view.funct3;
  assign exp_addr_o = addr;

endmodule

// ==== logic/lsu_access_matcher.sv ====
// A memory instruction must retire at least one cycle after its response strobe.
// All results are registered and appear one cycle after the event.

`timescale 1ns/1ps

module lsu_access_matcher (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rvfi_valid_i,
  input  logic [4:0]                    rvfi_rd_addr_i,
  input  logic [dcheck_pkg::XLEN-1:0]   rvfi_rd_wdata_i,
  input  logic                          rvfi_trap_i,
  input  logic                          is_mem_i,
  input  logic                          is_store_i,
  input  logic [2:0]                    funct3_i,
  input  logic [dcheck_pkg::XLEN-1:0]   exp_addr_i,
  input  logic [3:0]                    exp_be_i,
  input  logic [dcheck_pkg::XLEN-1:0]   exp_wdata_i,
  input  logic                          acc_valid_i,
  input  logic                          acc_we_i,
  input  logic [dcheck_pkg::XLEN-1:0]   acc_addr_i,
  input  logic [3:0]                    acc_be_i,
  input  logic [dcheck_pkg::XLEN-1:0]   acc_data_i,
  input  logic                          acc_err_i,
  input  logic                          overflow_i,
  output logic                          acc_pop_o,
  output logic                          mismatch_o,
  output logic [dcheck_pkg::KIND_W-1:0] mismatch_kind_o,
  output logic [15:0]                   checked_count_o
);
  import dcheck_pkg::*;

  logic              mem_ret;
  logic [XLEN-1:0]   be_mask;
  logic [XLEN-1:0]   lane_word;
  logic [XLEN-1:0]   load_val;
  logic              store_bad;
  logic              load_bad;
  logic [KIND_W-1:0] kind;

  logic              mismatch_q;
  logic [KIND_W-1:0] kind_q;
  logic [15:0]       count_q;

  assign mem_ret   = rvfi_valid_i && is_mem_i;
  assign acc_pop_o = mem_ret && acc_valid_i;

  // --------------------------------------------------
  // data checks
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      be_mask[8*i +: 8] = {8{exp_be_i[i]}};
    end
  end

  assign lane_word = acc_data_i >> {exp_addr_i[1:0], 3'b000};

  always_comb begin
    case (funct3_i)
      F3_B:    load_val = {{(XLEN-8){lane_word[7]}}, lane_word[7:0]};
      F3_BU:   load_val = {{(XLEN-8){1'b0}}, lane_word[7:0]};
      F3_H:    load_val = {{(XLEN-16){lane_word[15]}}, lane_word[15:0]};
      F3_HU:   load_val = {{(XLEN-16){1'b0}}, lane_word[15:0]};
      default: load_val = lane_word;
    endcase
  end

  assign store_bad = is_store_i && ((acc_data_i & be_mask) != (exp_wdata_i & be_mask));

  // x0 is never written, so whatever rd_wdata shows for it is ignored
  assign load_bad = !is_store_i && !rvfi_trap_i && (rvfi_rd_addr_i != 5'd0) &&
                    (rvfi_rd_wdata_i != load_val);

  // --------------------------------------------------
  // priority select of the mismatch kind
  // --------------------------------------------------
  always_comb begin
    kind = MM_NONE;
    if (overflow_i) begin
      kind = MM_OVERFLOW;
    end else if (mem_ret) begin
      if (!acc_valid_i) begin
        kind = MM_MISSING;
      end else if (rvfi_trap_i != acc_err_i) begin
        kind = MM_ERR;
      end else if ((acc_we_i != is_store_i) || (acc_addr_i != exp_addr_i)) begin
        kind = MM_ADDR;
      end else if (acc_be_i != exp_be_i) begin
        kind = MM_BE;
      end else if (store_bad || load_bad) begin
        kind = MM_DATA;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= 1'b0;
      kind_q     <= MM_NONE;
      count_q    <= '0;
    end else begin
      mismatch_q <= (kind != MM_NONE);
      kind_q     <= kind;
      if (mem_ret) begin
        count_q <= count_q + 16'd1;
      end
    end
  end

  assign mismatch_o      = mismatch_q;
  assign mismatch_kind_o = kind_q;
  assign checked_count_o = count_q;

endmodule

// ==== logic/dside_cosim_checker.sv ====
// Lockstep check of the data side only: no split accesses, no PMP or privilege.
// Retire a memory instruction at least one cycle after its response strobe.

`timescale 1ns/1ps

module dside_cosim_checker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          dmem_req_i,
  input  logic                          dmem_gnt_i,
  input  logic                          dmem_we_i,
  input  logic [dcheck_pkg::XLEN-1:0]   dmem_addr_i,
  input  logic [3:0]                    dmem_be_i,
  input  logic [dcheck_pkg::XLEN-1:0]   dmem_wdata_i,
  input  logic                          dmem_rvalid_i,
  input  logic [dcheck_pkg::XLEN-1:0]   dmem_rdata_i,
  input  logic                          dmem_err_i,
  input  logic                          rvfi_valid_i,
  input  logic [31:0]                   rvfi_insn_i,
  input  logic [dcheck_pkg::XLEN-1:0]   rvfi_rs1_rdata_i,
  input  logic [dcheck_pkg::XLEN-1:0]   rvfi_rs2_rdata_i,
  input  logic [4:0]                    rvfi_rd_addr_i,
  input  logic [dcheck_pkg::XLEN-1:0]   rvfi_rd_wdata_i,
  input  logic                          rvfi_trap_i,
  output logic                          mismatch_o,
  output logic [dcheck_pkg::KIND_W-1:0] mismatch_kind_o,
  output logic [15:0]                   checked_count_o
);
  import dcheck_pkg::*;

  logic            acc_valid;
  logic            acc_head_we;
  logic [XLEN-1:0] acc_head_addr;
  logic [3:0]      acc_head_be;
  logic [XLEN-1:0] acc_head_data;
  logic            acc_head_err;
  logic            acc_pop;
  logic            overflow;

  logic            is_mem;
  logic            is_store;
  logic [2:0]      funct3;
  logic [XLEN-1:0] exp_addr;
  logic [3:0]      exp_be;
  logic [XLEN-1:0] exp_wdata_lanes;

  dmem_access_tracker u_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dmem_req_i    (dmem_req_i),
    .dmem_gnt_i    (dmem_gnt_i),
    .dmem_we_i     (dmem_we_i),
    .dmem_addr_i   (dmem_addr_i),
    .dmem_be_i     (dmem_be_i),
    .dmem_wdata_i  (dmem_wdata_i),
    .dmem_rvalid_i (dmem_rvalid_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .dmem_err_i    (dmem_err_i),
    .acc_pop_i     (acc_pop),
    .acc_valid_o   (acc_valid),
    .acc_we_o      (acc_head_we),
    .acc_addr_o    (acc_head_addr),
    .acc_be_o      (acc_head_be),
    .acc_data_o    (acc_head_data),
    .acc_err_o     (acc_head_err),
    .overflow_o    (overflow)
  );

  retire_lsu_decoder u_decoder (
    .rvfi_insn_i      (rvfi_insn_i),
    .rvfi_rs1_rdata_i (rvfi_rs1_rdata_i),
    .rvfi_rs2_rdata_i (rvfi_rs2_rdata_i),
    .is_mem_o         (is_mem),
    .is_store_o       (is_store),
    .funct3_o         (funct3),
    .exp_addr_o       (exp_addr),
    .exp_be_o         (exp_be),
    .exp_wdata_o      (exp_wdata_lanes)
  );

  lsu_access_matcher u_matcher (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rvfi_valid_i    (rvfi_valid_i),
    .rvfi_rd_addr_i  (rvfi_rd_addr_i),
    .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
    .rvfi_trap_i     (rvfi_trap_i),
    .is_mem_i        (is_mem),
    .is_store_i      (is_store),
    .funct3_i        (funct3),
    .exp_addr_i      (exp_addr),
    .exp_be_i        (exp_be),
    .exp_wdata_i     (exp_wdata_lanes),
    .acc_valid_i     (acc_valid),
    .acc_we_i        (acc_head_we),
    .acc_addr_i      (acc_head_addr),
    .acc_be_i        (acc_head_be),
    .acc_data_i      (acc_head_data),
    .acc_err_i       (acc_head_err),
    .overflow_i      (overflow),
    .acc_pop_o       (acc_pop),
    .mismatch_o      (mismatch_o),
    .mismatch_kind_o (mismatch_kind_o),
    .checked_count_o (checked_count_o)
  );

endmodule

// ==== verification/dside_cosim_checker_sva.sv ====
// Sees only the top-level ports of dside_cosim_checker.
// Protocol checks assume a single outstanding data bus request.

`timescale 1ns/1ps

module dside_cosim_checker_sva (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          dmem_req_i,
  input logic                          dmem_gnt_i,
  input logic                          dmem_rvalid_i,
  input logic                          mismatch_i,
  input logic [dcheck_pkg::KIND_W-1:0] mismatch_kind_i,
  input logic [15:0]                   checked_count_i
);
  import dcheck_pkg::*;

  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (dmem_req_i && dmem_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (dmem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  reset_quiet_a: assert property (@(posedge clk_i) !rst_ni |-> !mismatch_i)
    else $error("mismatch_o high during reset");

  one_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dmem_req_i && dmem_gnt_i) |-> (!outstanding_q || dmem_rvalid_i))
    else $error("second request granted while one is outstanding");

  rvalid_has_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_rvalid_i |-> outstanding_q)
    else $error("response strobe without a granted request");

  kind_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !mismatch_i |-> (mismatch_kind_i == MM_NONE))
    else $error("mismatch kind set while mismatch_o is low");

  count_mono_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    checked_count_i >= $past(checked_count_i))
    else $error("checked count decreased");

endmodule

bind dside_cosim_checker dside_cosim_checker_sva u_sva (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .dmem_req_i      (dmem_req_i),
  .dmem_gnt_i      (dmem_gnt_i),
  .dmem_rvalid_i   (dmem_rvalid_i),
  .mismatch_i      (mismatch_o),
  .mismatch_kind_i (mismatch_kind_o),
  .checked_count_i (checked_count_o)
);

// ==== verification/tb_dside_cosim_checker.sv ====
// Random lockstep stimulus with one memory instruction per bus transfer, retired 1 to 3
// cycles after its response. Addresses stay in a 256 byte window mirrored by a
// software memory.

`timescale 1ns/1ps

module tb_dside_cosim_checker;
  import dcheck_pkg::*;

  localparam int N_CLEAN     = 48;
  localparam int N_FAULTS    = 9;
  localparam int N_ISSUED    = N_CLEAN + (N_CLEAN + 2) / 3 + N_FAULTS + 3;
  localparam int CYCLE_LIMIT = 40 * N_ISSUED + 100;

  // each fault selector corrupts one field of one instruction
  localparam int F_NONE   = 0;
  localparam int F_ADDR   = 1;
  localparam int F_DIR    = 2;
  localparam int F_BE     = 3;
  localparam int F_LANE   = 4;
  localparam int F_EXT    = 5;
  localparam int F_RD0    = 6;
  localparam int F_BUSERR = 7;
  localparam int F_TRAP   = 8;
  localparam int F_NOACC  = 9;

  logic              clk_i;
  logic              rst_ni;
  logic              dmem_req_i;
  logic              dmem_gnt_i;
  logic              dmem_we_i;
  logic [XLEN-1:0]   dmem_addr_i;
  logic [3:0]        dmem_be_i;
  logic [XLEN-1:0]   dmem_wdata_i;
  logic              dmem_rvalid_i;
  logic [XLEN-1:0]   dmem_rdata_i;
  logic              dmem_err_i;
  logic              rvfi_valid_i;
  logic [31:0]       rvfi_insn_i;
  logic [XLEN-1:0]   rvfi_rs1_rdata_i;
  logic [XLEN-1:0]   rvfi_rs2_rdata_i;
  logic [4:0]        rvfi_rd_addr_i;
  logic [XLEN-1:0]   rvfi_rd_wdata_i;
  logic              rvfi_trap_i;
  logic              mismatch_o;
  logic [KIND_W-1:0] mismatch_kind_o;
  logic [15:0]       checked_count_o;

  logic [31:0]       mem [64];
  logic [KIND_W-1:0] exp_kind_q [$];
  logic [15:0]       exp_count_q [$];
  logic [136:0]      deferred_q [$];
  logic [15:0]       exp_count;
  logic [KIND_W-1:0] cmp_kind;
  logic [15:0]       cmp_count;
  logic              chk_en;
  logic              chk_pending;
  int                errors;
  int                cycles;
  int                seed_val;

  dside_cosim_checker u_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmem_req_i       (dmem_req_i),
    .dmem_gnt_i       (dmem_gnt_i),
    .dmem_we_i        (dmem_we_i),
    .dmem_addr_i      (dmem_addr_i),
    .dmem_be_i        (dmem_be_i),
    .dmem_wdata_i     (dmem_wdata_i),
    .dmem_rvalid_i    (dmem_rvalid_i),
    .dmem_rdata_i     (dmem_rdata_i),
    .dmem_err_i       (dmem_err_i),
    .rvfi_valid_i     (rvfi_valid_i),
    .rvfi_insn_i      (rvfi_insn_i),
    .rvfi_rs1_rdata_i (rvfi_rs1_rdata_i),
    .rvfi_rs2_rdata_i (rvfi_rs2_rdata_i),
    .rvfi_rd_addr_i   (rvfi_rd_addr_i),
    .rvfi_rd_wdata_i  (rvfi_rd_wdata_i),
    .rvfi_trap_i      (rvfi_trap_i),
    .mismatch_o       (mismatch_o),
    .mismatch_kind_o  (mismatch_kind_o),
    .checked_count_o  (checked_count_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [31:0] extract_load(input logic [31:0] word, input logic [1:0] off,
                                               input logic [2:0] f3);
    logic [31:0] v;
    v = word >> (8 * off);
    case (f3[1:0])
      2'b00:   v = f3[2] ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
      2'b01:   v = f3[2] ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
      default: ;
    endcase
    return v;
  endfunction

  function automatic logic [KIND_W-1:0] expected_kind(
      input logic acc_seen, input logic bus_we, input logic [31:0] bus_addr,
      input logic [3:0] bus_be, input logic [31:0] bus_data, input logic bus_err,
      input logic [31:0] insn_w, input logic [31:0] rs1, input logic [31:0] rs2,
      input logic [4:0] rd, input logic [31:0] rd_wdata, input logic trap);
    lsu_insn_u   w;
    logic        st;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [3:0]  be;
    logic        lanes_ok;
    int          nbytes;
    w  = insn_w;
    st = (w.s_view.opcode == OPC_STORE);
    if (!st && (w.i_view.opcode != OPC_LOAD)) return MM_NONE;
    if (!acc_seen) return MM_MISSING;
    if (trap != bus_err) return MM_ERR;
    if (st) imm = {{20{w.s_view.imm_hi[6]}}, w.s_view.imm_hi, w.s_view.imm_lo};
    else imm = {{20{w.i_view.imm[11]}}, w.i_view.imm};
    addr = rs1 + imm;
    if ((bus_we != st) || (bus_addr != addr)) return MM_ADDR;
    nbytes   = (w.i_view.funct3[1:0] == 2'b00) ? 1 : (w.i_view.funct3[1:0] == 2'b01) ? 2 : 4;
    be       = '0;
    lanes_ok = 1'b1;
    for (int k = 0; k < nbytes; k++) begin
      be[addr[1:0] + k] = 1'b1;
      if (bus_data[8 * (addr[1:0] + k) +: 8] != rs2[8 * k +: 8]) lanes_ok = 1'b0;
    end
    if (bus_be != be) return MM_BE;
    if (st && !lanes_ok) return MM_DATA;
    if (!st && !trap && (rd != 5'd0) &&
        (rd_wdata != extract_load(bus_data, addr[1:0], w.i_view.funct3))) return MM_DATA;
    return MM_NONE;
  endfunction

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic bus_transfer(input logic we, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, input logic [31:0] rdata,
                              input logic err, input logic expect_ovf);
    dmem_req_i   = 1'b1;
    dmem_we_i    = we;
    dmem_addr_i  = addr;
    dmem_be_i    = be;
    dmem_wdata_i = wdata;
    repeat ($urandom % 3) next_cycle();
    dmem_gnt_i = 1'b1;
    next_cycle();
    dmem_req_i = 1'b0;
    dmem_gnt_i = 1'b0;
    repeat ($urandom % 3) next_cycle();
    dmem_rvalid_i = 1'b1;
    dmem_rdata_i  = rdata;
    dmem_err_i    = err;
    if (expect_ovf) begin
      exp_kind_q.push_back(MM_OVERFLOW);
      exp_count_q.push_back(exp_count);
      chk_en = 1'b1;
    end
    next_cycle();
    dmem_rvalid_i = 1'b0;
    dmem_err_i    = 1'b0;
    chk_en        = 1'b0;
  endtask

  task automatic retire_insn(input logic [31:0] insn, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic [4:0] rd,
                             input logic [31:0] rd_wdata, input logic trap,
                             input logic [KIND_W-1:0] kind, input logic is_mem);
    repeat ($urandom % 3) next_cycle();
    if (is_mem) exp_count = exp_count + 16'd1;
    exp_kind_q.push_back(kind);
    exp_count_q.push_back(exp_count);
    rvfi_valid_i     = 1'b1;
    rvfi_insn_i      = insn;
    rvfi_rs1_rdata_i = rs1;
    rvfi_rs2_rdata_i = rs2;
    rvfi_rd_addr_i   = rd;
    rvfi_rd_wdata_i  = rd_wdata;
    rvfi_trap_i      = trap;
    chk_en           = 1'b1;
    next_cycle();
    rvfi_valid_i = 1'b0;
    rvfi_trap_i  = 1'b0;
    chk_en       = 1'b0;
  endtask

  task automatic issue_alu();
    logic [31:0] insn;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] wd;
    logic [4:0]  rd;
    insn = {25'($urandom), 7'b0010011};
    rs1  = $urandom;
    rs2  = $urandom;
    wd   = $urandom;
    rd   = 5'($urandom);
    retire_insn(insn, rs1, rs2, rd, wd, 1'b0,
                expected_kind(1'b0, 1'b0, '0, '0, '0, 1'b0, insn, rs1, rs2, rd, wd, 1'b0),
                1'b0);
  endtask

  task automatic run_mem_access(input int fault, input logic defer, input logic ovf);
    lsu_insn_u         w;
    logic              st;
    logic              bus_we;
    logic              err;
    logic              trap;
    logic [2:0]        f3;
    logic [1:0]        off;
    logic [5:0]        wi;
    logic [11:0]       imm12;
    logic [4:0]        rd;
    logic [3:0]        bus_be;
    logic [31:0]       addr;
    logic [31:0]       rs1;
    logic [31:0]       rs2;
    logic [31:0]       bus_addr;
    logic [31:0]       bus_wdata;
    logic [31:0]       bus_rdata;
    logic [31:0]       rd_wdata;
    logic [KIND_W-1:0] kind;
    int                nbytes;
    if (fault == F_LANE) st = 1'b1;
    else if ((fault == F_EXT) || (fault == F_RD0)) st = 1'b0;
    else st = 1'($urandom);
    case ($urandom % (st ? 3 : 5))
      0:       f3 = F3_B;
      1:       f3 = F3_H;
      2:       f3 = F3_W;
      3:       f3 = F3_BU;
      default: f3 = F3_HU;
    endcase
    // extension faults need a sub-word load
    if ((fault == F_EXT) && (f3 == F3_W)) f3 = F3_HU;
    nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    off    = 2'($urandom) & ~2'(nbytes - 1);
    wi     = 6'($urandom);
    addr   = 32'h8000_0000 | {24'h0, wi, off};
    imm12  = 12'($urandom);
    rs1    = addr - {{20{imm12[11]}}, imm12};
    rs2    = $urandom;
    rd     = (st || (fault == F_RD0)) ? 5'd0 : 5'($urandom_range(31, 1));
    if (st) w.s_view = {imm12[11:5], 5'($urandom), 5'($urandom), f3, imm12[4:0], OPC_STORE};
    else w.i_view = {imm12, 5'($urandom), f3, rd, OPC_LOAD};

    bus_we    = st;
    bus_addr  = addr;
    bus_be    = 4'(((1 << nbytes) - 1) << off);
    bus_wdata = $urandom;
    for (int j = 0; j < 4; j++) begin
      if (bus_be[j]) bus_wdata[8 * j +: 8] = rs2[8 * (j - off) +: 8];
    end
    bus_rdata = st ? $urandom : mem[wi];
    rd_wdata  = st ? 32'h0 : extract_load(mem[wi], off, f3);
    if (st) begin
      for (int j = 0; j < 4; j++) begin
        if (bus_be[j]) mem[wi][8 * j +: 8] = bus_wdata[8 * j +: 8];
      end
    end
    err  = 1'b0;
    trap = 1'b0;
    // a faulting access that traps cleanly is also legal
    if ((fault == F_NONE) && (($urandom % 8) == 0)) begin
      err  = 1'b1;
      trap = 1'b1;
    end

    case (fault)
      F_ADDR:   bus_addr = bus_addr ^ 32'h0000_0040;
      F_DIR:    bus_we = !bus_we;
      F_BE:     bus_be = bus_be ^ 4'(1 << ($urandom % 4));
      F_LANE:   bus_wdata = bus_wdata ^ (32'h1 << (8 * off));
      F_EXT:    rd_wdata = rd_wdata ^ 32'h8000_0000;
      F_RD0:    rd_wdata = $urandom;
      F_BUSERR: err = 1'b1;
      F_TRAP:   trap = 1'b1;
      default:  ;
    endcase

    kind = expected_kind(fault != F_NOACC, bus_we, bus_addr, bus_be,
                         bus_we ? bus_wdata : bus_rdata, err, w, rs1, rs2, rd, rd_wdata, trap);
    if (fault != F_NOACC) bus_transfer(bus_we, bus_addr, bus_be, bus_wdata, bus_rdata, err, ovf);
    if (!defer) retire_insn(w, rs1, rs2, rd, rd_wdata, trap, kind, 1'b1);
    else if (!ovf) deferred_q.push_back({w, rs1, rs2, rd, rd_wdata, trap, kind});
  endtask

  task automatic replay_deferred();
    logic [31:0]       insn;
    logic [31:0]       rs1;
    logic [31:0]       rs2;
    logic [31:0]       wd;
    logic [4:0]        rd;
    logic              trap;
    logic [KIND_W-1:0] kind;
    while (deferred_q.size() != 0) begin
      {insn, rs1, rs2, rd, wd, trap, kind} = deferred_q.pop_front();
      retire_insn(insn, rs1, rs2, rd, wd, trap, kind, 1'b1);
    end
  endtask

  // --------------------------------------------------
  // compare
  // --------------------------------------------------
  task automatic check_kind(input logic [KIND_W-1:0] got, input logic [KIND_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t mismatch_kind_o got=%0d exp=%0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t mismatch_o got=%0b exp=%0b", $time, got, exp);
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t checked_count_o got=%0d exp=%0d", $time, got, exp);
    end
  endtask

  // results are registered, so they are sampled at the falling edge one cycle later
  always @(negedge clk_i) begin
    if (chk_pending) begin
      if (exp_kind_q.size() == 0) begin
        errors++;
        $display("compare at %0t found no expected result queued", $time);
      end else begin
        cmp_kind  = exp_kind_q.pop_front();
        cmp_count = exp_count_q.pop_front();
        check_kind(mismatch_kind_o, cmp_kind);
        check_flag(mismatch_o, cmp_kind != MM_NONE);
        check_count(checked_count_o, cmp_count);
      end
    end else if (rst_ni && mismatch_o) begin
      errors++;
      $display("mismatch_o pulsed at %0t with no retirement or response behind it", $time);
    end
    chk_pending = chk_en;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed_val         = $urandom(32'hbfad);
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    dmem_req_i       = 1'b0;
    dmem_gnt_i       = 1'b0;
    dmem_we_i        = 1'b0;
    dmem_addr_i      = '0;
    dmem_be_i        = '0;
    dmem_wdata_i     = '0;
    dmem_rvalid_i    = 1'b0;
    dmem_rdata_i     = '0;
    dmem_err_i       = 1'b0;
    rvfi_valid_i     = 1'b0;
    rvfi_insn_i      = '0;
    rvfi_rs1_rdata_i = '0;
    rvfi_rs2_rdata_i = '0;
    rvfi_rd_addr_i   = '0;
    rvfi_rd_wdata_i  = '0;
    rvfi_trap_i      = 1'b0;
    chk_en           = 1'b0;
    chk_pending      = 1'b0;
    exp_count        = '0;
    errors           = 0;
    cycles           = 0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = {8'(i), 8'(~i), 8'(i * 37), 8'(i ^ 8'h5a)};
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();

    for (int i = 0; i < N_CLEAN; i++) begin
      run_mem_access(F_NONE, 1'b0, 1'b0);
      if ((i % 3) == 0) issue_alu();
    end
    for (int f = F_ADDR; f <= F_NOACC; f++) begin
      run_mem_access(f, 1'b0, 1'b0);
    end
    // two accesses fill the queue and the third response overflows
    run_mem_access(F_NONE, 1'b1, 1'b0);
    run_mem_access(F_NONE, 1'b1, 1'b0);
    run_mem_access(F_NONE, 1'b1, 1'b1);
    replay_deferred();
    repeat (3) next_cycle();

    if (exp_kind_q.size() != 0) begin
      errors++;
      $display("%0d expected results were never compared", exp_kind_q.size());
    end
    $display("errors: %0d, cycles: %0d", errors, cycles);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
logic/dcheck_pkg.sv
logic/dmem_access_tracker.sv
logic/retire_lsu_decoder.sv
logic/lsu_access_matcher.sv
logic/dside_cosim_checker.sv
verification/dside_cosim_checker_sva.sv
verification/tb_dside_cosim_checker.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dside_cosim_checker \
  -f project.f --Mdir obj_dir -o sim_dside
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_dside)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
